// ==== hw/MemoryArbiter.sv ====
`timescale 1ns/100ps

module MemoryArbiter import MemoryPkg::*; (
	input logic clk,
	input logic rst,

	// Ring A.
	input logic reqA,
	input logic writeA,
	input logic [AddrWidth-1:0] addrA,
	input logic [DataWidth-1:0] wDataA,
	output logic ackA,

	// Ring B.
	input logic reqB,
	input logic writeB,
	input logic [AddrWidth-1:0] addrB,
	input logic [DataWidth-1:0] wDataB,
	output logic ackB,

	output logic [DataWidth-1:0] rData, // Valid with either ack.

	// RAM port.
	output logic ramEn,
	output logic ramWe,
	output logic [AddrWidth-1:0] ramAddr,
	output logic [DataWidth-1:0] ramWData,
	input logic [DataWidth-1:0] ramRData
);

	logic lastServed; // Also names the client on the RAM while ramEn is high.
	logic eligA;
	logic eligB;
	logic pickB;
	logic grant;

	// A client is skipped while its access is on the RAM or being acked,
	// since its request is still high then.
	assign eligA = reqA && !ackA && !(ramEn && lastServed == ClientA);
	assign eligB = reqB && !ackB && !(ramEn && lastServed == ClientB);

	// Round robin.
	assign pickB = eligB && (!eligA || lastServed == ClientA);
	assign grant = eligA || eligB;

	always_ff @(posedge clk) begin
		if (rst) begin
			ramEn <= 1'b0;
			ramWe <= 1'b0;
			ackA <= 1'b0;
			ackB <= 1'b0;
			lastServed <= ClientB;
		end else begin
			ackA <= ramEn && lastServed == ClientA;
			ackB <= ramEn && lastServed == ClientB;
			ramEn <= grant;
			if (grant) begin
				lastServed <= pickB ? ClientB : ClientA;
				ramWe <= pickB ? writeB : writeA;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			ramAddr <= pickB ? addrB : addrA;
			ramWData <= pickB ? wDataB : wDataA;
		end
	end

	// RAM output register lines up with the ack.
	assign rData = ramRData;

	// Each ack answers a request that its ring still holds.
	assert property (@(posedge clk) disable iff (rst) (!ackA || reqA) && (!ackB || reqB));

endmodule

// ==== hw/MemoryBlock.sv ====
`timescale 1ns/100ps

module MemoryBlock import MemoryPkg::*; (
	input logic clk,
	input logic rst,

	// Ring A.
	input logic clearA,
	input logic pushReqA,
	input logic [DataWidth-1:0] pushDataA,
	input logic popReqA,
	output logic pushAckA,
	output logic popAckA,
	output logic [DataWidth-1:0] popDataA,
	output logic [CountWidth-1:0] countA,
	output logic emptyA,
	output logic fullA,

	// Ring B.
	input logic clearB,
	input logic pushReqB,
	input logic [DataWidth-1:0] pushDataB,
	input logic popReqB,
	output logic pushAckB,
	output logic popAckB,
	output logic [DataWidth-1:0] popDataB,
	output logic [CountWidth-1:0] countB,
	output logic emptyB,
	output logic fullB
);

	// Ring to arbiter.
	logic memReqA;
	logic memWriteA;
	logic [AddrWidth-1:0] memAddrA;
	logic [DataWidth-1:0] memWDataA;
	logic memAckA;
	logic memReqB;
	logic memWriteB;
	logic [AddrWidth-1:0] memAddrB;
	logic [DataWidth-1:0] memWDataB;
	logic memAckB;
	logic [DataWidth-1:0] memRData; // Shared, each ring samples on its own ack.

	// Arbiter to RAM.
	logic ramEn;
	logic ramWe;
	logic [AddrWidth-1:0] ramAddr;
	logic [DataWidth-1:0] ramWData;
	logic [DataWidth-1:0] ramRData;

	RingBuffer #(.MemStart(RingAStart), .MemEnd(RingAEnd)) ringA (
		.clk(clk), .rst(rst), .clear(clearA),
		.pushReq(pushReqA), .pushData(pushDataA), .pushAck(pushAckA),
		.popReq(popReqA), .popAck(popAckA), .popData(popDataA),
		.count(countA), .empty(emptyA), .full(fullA),
		.memReq(memReqA), .memWrite(memWriteA), .memAddr(memAddrA),
		.memWData(memWDataA), .memAck(memAckA), .memRData(memRData)
	);

	RingBuffer #(.MemStart(RingBStart), .MemEnd(RingBEnd)) ringB (
		.clk(clk), .rst(rst), .clear(clearB),
		.pushReq(pushReqB), .pushData(pushDataB), .pushAck(pushAckB),
		.popReq(popReqB), .popAck(popAckB), .popData(popDataB),
		.count(countB), .empty(emptyB), .full(fullB),
		.memReq(memReqB), .memWrite(memWriteB), .memAddr(memAddrB),
		.memWData(memWDataB), .memAck(memAckB), .memRData(memRData)
	);

	MemoryArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.reqA(memReqA),
		.writeA(memWriteA),
		.addrA(memAddrA),
		.wDataA(memWDataA),
		.ackA(memAckA),
		.reqB(memReqB),
		.writeB(memWriteB),
		.addrB(memAddrB),
		.wDataB(memWDataB),
		.ackB(memAckB),
		.rData(memRData),
		.ramEn(ramEn),
		.ramWe(ramWe),
		.ramAddr(ramAddr),
		.ramWData(ramWData),
		.ramRData(ramRData)
	);

	SharedMemory ram (
		.clk(clk),
		.ramEn(ramEn),
		.ramWe(ramWe),
		.ramAddr(ramAddr),
		.ramWData(ramWData),
		.ramRData(ramRData)
	);

endmodule

// ==== hw/MemoryPkg.sv ====
package MemoryPkg;

	// Word and address sizes of the shared RAM.
	localparam int DataWidth = 16;
	localparam int AddrWidth = 8;
	localparam int MemDepth = 256;

	// Region of ring A.
	localparam logic [AddrWidth-1:0] RingAStart = 8'd0;
	localparam logic [AddrWidth-1:0] RingAEnd = 8'd127;

	// Region of ring B.
	localparam logic [AddrWidth-1:0] RingBStart = 8'd128;
	localparam logic [AddrWidth-1:0] RingBEnd = 8'd255;

	localparam int RingDepth = 128; // Words per ring.
	localparam int CountWidth = 8; // Holds 0 to RingDepth.

	// Arbiter client indices, also the encoding of the last-served bit.
	localparam logic ClientA = 1'b0;
	localparam logic ClientB = 1'b1;

endpackage

// ==== hw/RingBuffer.sv ====
`timescale 1ns/100ps

module RingBuffer import MemoryPkg::*; #(
	parameter logic [AddrWidth-1:0] MemStart = RingAStart,
	parameter logic [AddrWidth-1:0] MemEnd = RingAEnd
) (
	input logic clk,
	input logic rst,
	input logic clear,

	// Producer side.
	input logic pushReq,
	input logic [DataWidth-1:0] pushData,
	output logic pushAck,

	// Consumer side.
	input logic popReq,
	output logic popAck,
	output logic [DataWidth-1:0] popData,

	// Status.
	output logic [CountWidth-1:0] count,
	output logic empty,
	output logic full,

	// Request port towards the arbiter.
	output logic memReq,
	output logic memWrite,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWData,
	input logic memAck,
	input logic [DataWidth-1:0] memRData
);

	logic [AddrWidth-1:0] head; // Next slot to be written.
	logic [AddrWidth-1:0] tail; // Oldest stored word.
	logic [AddrWidth-1:0] headNext;
	logic [AddrWidth-1:0] tailNext;

	logic idle;
	logic startPop;
	logic startPush;
	logic doClear;
	logic memDone;

	// The FSM state lives in the request and ack flags themselves.
	// Idle, memory write, memory read, push ack and pop ack are mutually exclusive.
	assign idle = !memReq && !pushAck && !popAck;

	assign empty = (count == '0);
	assign full = (count == CountWidth'(RingDepth));

	// Wrap at the end of the region.
	assign headNext = (head == MemEnd) ? MemStart : head + 1'b1;
	assign tailNext = (tail == MemEnd) ? MemStart : tail + 1'b1;

	// A pending pop wins over a pending push.
	assign startPop = idle && popReq && !empty;
	assign startPush = idle && pushReq && !full && !startPop;

	// Clear only between handshakes.
	assign doClear = idle && clear && !pushReq && !popReq;

	assign memDone = memReq && memAck;

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= MemStart;
			tail <= MemStart;
			count <= '0;
			memReq <= 1'b0;
			memWrite <= 1'b0;
			pushAck <= 1'b0;
			popAck <= 1'b0;
		end else if (doClear) begin
			head <= MemStart;
			tail <= MemStart;
			count <= '0;
		end else if (startPop || startPush) begin
			memReq <= 1'b1;
			memWrite <= startPush;
		end else if (memDone) begin
			memReq <= 1'b0; // Released the cycle after the ack.
			if (memWrite) begin
				head <= headNext;
				count <= count + 1'b1;
				pushAck <= 1'b1;
			end else begin
				tail <= tailNext;
				count <= count - 1'b1;
				popAck <= 1'b1;
			end
		end else if (pushAck && !pushReq) begin
			pushAck <= 1'b0;
		end else if (popAck && !popReq) begin
			popAck <= 1'b0;
		end
	end

	// Request fields and returned data.
	always_ff @(posedge clk) begin
		if (startPop || startPush) begin
			memAddr <= startPop ? tail : head;
			memWData <= pushData;
		end
		if (memDone && !memWrite) begin
			popData <= memRData; // Held while popAck is high.
		end
	end

	// Occupancy never passes the size of the region.
	assert property (@(posedge clk) disable iff (rst) count <= CountWidth'(RingDepth));

	// The arbiter may take several cycles, the request must not move meanwhile.
	assert property (@(posedge clk) disable iff (rst)
		memReq && !memAck |=> memReq && $stable(memAddr) && $stable(memWrite));

endmodule

// ==== hw/SharedMemory.sv ====
`timescale 1ns/100ps

module SharedMemory import MemoryPkg::*; (
	input logic clk,
	input logic ramEn,
	input logic ramWe,
	input logic [AddrWidth-1:0] ramAddr,
	input logic [DataWidth-1:0] ramWData,
	output logic [DataWidth-1:0] ramRData
);

	logic [DataWidth-1:0] mem [MemDepth];

	// Write and registered read share the one address.
	always_ff @(posedge clk) begin
		if (ramEn) begin
			if (ramWe) begin
				mem[ramAddr] <= ramWData;
			end else begin
				ramRData <= mem[ramAddr]; // Ready one cycle later.
			end
		end
	end

endmodule

// ==== project.f ====
hw/MemoryPkg.sv
hw/RingBuffer.sv
hw/MemoryArbiter.sv
hw/SharedMemory.sv
hw/MemoryBlock.sv
testbench/ClockGen.sv
testbench/MemoryBlockTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the memory block testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module MemoryBlockTb \
	-Mdir "$BUILD" -o MemoryBlockTb \
	-f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/MemoryBlockTb" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== testbench/ClockGen.sv ====
`timescale 1ns/100ps

module ClockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== testbench/MemoryBlockTb.sv ====
`timescale 1ns/100ps

module MemoryBlockTb import MemoryPkg::*; ();

	localparam int FifoOps = 80;
	localparam int MixOps = 60;
	localparam int ClearFill = 6;
	localparam int ClearOps = 20;
	// Every random push may need a pop later to drain it.
	localparam int OpBound = 2 * FifoOps + 4 * MixOps + 2 * (RingDepth + 1) + 2
		+ 4 * ClearFill + 2 * ClearOps;
	localparam int CycleLimit = 2 * OpBound * 8;

	logic clk;
	logic rst;
	logic clear [2];
	logic pushReq [2];
	logic [DataWidth-1:0] pushData [2];
	logic popReq [2];
	logic pushAck [2];
	logic popAck [2];
	logic [DataWidth-1:0] popData [2];
	logic [CountWidth-1:0] count [2];
	logic empty [2];
	logic full [2];

	logic [DataWidth-1:0] modelA [$];
	logic [DataWidth-1:0] modelB [$];
	logic [15:0] lfsr = 16'd10;
	string testName = "reset";
	int cycleCount = 0;

	ClockGen clockGen (.clk(clk), .rst(rst));

	MemoryBlock UUT (
		.clk(clk), .rst(rst),
		.clearA(clear[0]), .pushReqA(pushReq[0]), .pushDataA(pushData[0]),
		.popReqA(popReq[0]), .pushAckA(pushAck[0]), .popAckA(popAck[0]),
		.popDataA(popData[0]), .countA(count[0]), .emptyA(empty[0]), .fullA(full[0]),
		.clearB(clear[1]), .pushReqB(pushReq[1]), .pushDataB(pushData[1]),
		.popReqB(popReq[1]), .pushAckB(pushAck[1]), .popAckB(popAck[1]),
		.popDataB(popData[1]), .countB(count[1]), .emptyB(empty[1]), .fullB(full[1])
	);

	task automatic stopWithFailure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("ERROR %s %s: expected %0h, actual %0h", testName, what, expected, actual);
			stopWithFailure();
		end
	endtask

	// Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic nextBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [15:0] randomValue(input int bits);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < bits; i++) v = {v[14:0], nextBit()};
		return v;
	endfunction

	function automatic int modelSize(input int ring);
		return (ring == 0) ? modelA.size() : modelB.size();
	endfunction

	task automatic checkStatus(input int ring);
		int size;
		size = modelSize(ring);
		checkValue($sformatf("count %0d", ring), size, int'(count[ring]));
		checkValue($sformatf("empty %0d", ring), int'(size == 0), int'(empty[ring]));
		checkValue($sformatf("full %0d", ring), int'(size == RingDepth), int'(full[ring]));
	endtask

	task automatic pushWord(input int ring, input logic [DataWidth-1:0] data);
		@(posedge clk);
		#1;
		pushData[ring] = data;
		pushReq[ring] = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!pushAck[ring]);
		if (ring == 0) modelA.push_back(data);
		else modelB.push_back(data);
		pushReq[ring] = 1'b0;
		@(posedge clk);
		#1;
		checkValue("push ack release", 0, int'(pushAck[ring])); // One cycle after req.
		checkStatus(ring);
	endtask

	task automatic popWord(input int ring);
		logic [DataWidth-1:0] expected;
		@(posedge clk);
		#1;
		popReq[ring] = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!popAck[ring]);
		assert (modelSize(ring) > 0) else begin
			$display("Ring %0d acknowledged a pop while the model holds no word", ring);
			stopWithFailure();
		end
		expected = (ring == 0) ? modelA.pop_front() : modelB.pop_front();
		checkValue($sformatf("pop data %0d", ring), int'(expected), int'(popData[ring]));
		popReq[ring] = 1'b0;
		@(posedge clk);
		#1;
		checkValue("pop ack release", 0, int'(popAck[ring]));
		checkStatus(ring);
	endtask

	task automatic randomOp(input int ring);
		int size;
		size = modelSize(ring);
		if (size == 0 || (size < RingDepth && nextBit())) pushWord(ring, randomValue(16));
		else popWord(ring);
		repeat (int'(randomValue(2))) @(posedge clk); // Idle gap.
	endtask

	task automatic drainRing(input int ring);
		while (modelSize(ring) > 0) popWord(ring);
	endtask

	task automatic clearRing(input int ring);
		@(posedge clk);
		#1;
		clear[ring] = 1'b1;
		@(posedge clk);
		#1;
		clear[ring] = 1'b0;
		if (ring == 0) modelA.delete();
		else modelB.delete();
		checkStatus(ring);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: a handshake never finished within %0d cycles", CycleLimit);
			stopWithFailure();
		end
	end

	initial begin
		for (int r = 0; r < 2; r++) begin
			clear[r] = 1'b0;
			pushReq[r] = 1'b0;
			popReq[r] = 1'b0;
			pushData[r] = '0;
		end
		do begin
			@(posedge clk);
		end while (rst);
		#1;
		for (int r = 0; r < 2; r++) begin
			checkStatus(r);
			checkValue("push ack after reset", 0, int'(pushAck[r]));
			checkValue("pop ack after reset", 0, int'(popAck[r]));
		end

		testName = "fifo order";
		repeat (FifoOps) randomOp(0);
		drainRing(0);

		testName = "independence";
		fork
			repeat (MixOps) randomOp(0);
			repeat (MixOps) randomOp(1);
		join
		fork
			drainRing(0);
			drainRing(1);
		join

		testName = "full back-pressure";
		while (modelSize(0) < RingDepth) pushWord(0, randomValue(16));
		fork
			pushWord(0, randomValue(16));
			begin
				repeat (12) begin
					@(posedge clk);
					#1;
					checkValue("push ack while full", 0, int'(pushAck[0]));
				end
				popWord(0);
			end
		join
		drainRing(0); // The late word comes out last.

		testName = "empty wait";
		fork
			popWord(1);
			begin
				repeat (10) begin
					@(posedge clk);
					#1;
					checkValue("pop ack while empty", 0, int'(popAck[1]));
				end
				pushWord(1, randomValue(16));
			end
		join

		testName = "clear";
		repeat (ClearFill) pushWord(0, randomValue(16));
		repeat (ClearFill) pushWord(1, randomValue(16));
		clearRing(0);
		checkStatus(1);
		repeat (ClearOps) randomOp(0);
		drainRing(1);
		drainRing(0);

		$display("All checks passed");
		$finish;
	end

endmodule
